//--- verilog/audio_pkg.sv
package audio_pkg;

  localparam int SAMPLE_W    = 16;  // Codec sample width
  localparam int AMP_SHIFT   = 12;  // Low ones under the amplitude code
  localparam int FIFO_DEPTH  = 8;   // Frames of buffering
  localparam int PEAK_WINDOW = 64;  // Frame slots per meter window
  localparam int PEAK_SHIFT  = 12;  // One LED per 4096 of peak
  localparam int LED_BARS    = 18;  // Red LED count on the board

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // One DAC sample

  // Payload of the sample FIFO, left in the upper half
  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_frame_t;

  // Switch settings for the tone
  typedef struct packed {
    logic       enable;       // Tone on
    logic       antiphase;    // Right is the inverted level
    logic [5:0] half_period;  // Run length minus one, in frames
    logic [2:0] amp_code;     // Amplitude step
  } tone_cfg_t;

  // Code 0 gives 0x0FFF, code 7 gives full scale 0x7FFF
  function automatic sample_t tone_amplitude(logic [2:0] amp_code);
    return sample_t'({1'b0, amp_code, {AMP_SHIFT{1'b1}}});
  endfunction

endpackage

//--- verilog/square_tone_gen.sv
`timescale 1ns/1ps

module square_tone_gen (
  input  logic                     AUD_DACLRCK,  // One edge per stereo frame
  input  logic                     reset,        // Sync, active high
  input  audio_pkg::tone_cfg_t     cfg,          // Switch settings
  input  logic                     full,         // FIFO back-pressure
  output logic                     push,         // Frame strobe into FIFO
  output audio_pkg::stereo_frame_t push_frame    // Frame offered on push
);

  logic                tone_run;   // Registered enable
  logic [5:0]          run_cnt;    // Frames spent at current level
  logic                level_hi;   // Square wave phase
  audio_pkg::sample_t  amp;        // Decoded amplitude
  audio_pkg::sample_t  left_smp;   // Left sample of current frame
  audio_pkg::sample_t  right_smp;  // Right sample of current frame

  assign amp = audio_pkg::tone_amplitude(cfg.amp_code);

  // Enable is sampled once per frame so push stays low right out of reset
  always_ff @(posedge AUD_DACLRCK) begin
    if (reset) begin
      tone_run <= 1'b0;
    end else begin
      tone_run <= cfg.enable;
    end
  end

  // Stall whenever the buffer is full
  assign push = tone_run && !full;

  // Counter and level move only on an accepted frame
  always_ff @(posedge AUD_DACLRCK) begin
    if (reset) begin
      run_cnt  <= '0;
      level_hi <= 1'b0;  // Start on the zero level
    end else if (push) begin
      if (run_cnt >= cfg.half_period) begin  // Also recovers from a shrunk setting
        run_cnt  <= '0;
        level_hi <= ~level_hi;  // Flip at end of run
      end else begin
        run_cnt <= run_cnt + 6'd1;
      end
    end
  end

  // Sample values from the level flag
  always_comb begin
    left_smp = level_hi ? amp : '0;  // Zero or amplitude
    if (cfg.antiphase) begin
      right_smp = left_smp ^ amp;  // Opposite level
    end else begin
      right_smp = left_smp;  // Same as left
    end
  end

  always_comb begin
    push_frame       = '0;
    push_frame.left  = left_smp;
    push_frame.right = right_smp;
  end

  // Counter stays inside the run while the run length is steady
  a_run_cnt_in_range: assert property (
    @(posedge AUD_DACLRCK) disable iff (reset)
    push |=> (!$stable(cfg.half_period) || (run_cnt <= cfg.half_period))
  ) else $error("square_tone_gen run counter passed the half period");

endmodule

//--- verilog/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
  parameter type payload_t = audio_pkg::stereo_frame_t,  // Entry type
  parameter int  DEPTH     = audio_pkg::FIFO_DEPTH       // Entry count
) (
  input  logic     AUD_DACLRCK,  // Frame clock
  input  logic     reset,        // Sync, active high
  input  logic     push,         // Write strobe
  input  payload_t push_frame,   // Write data
  input  logic     pop,          // Read strobe
  output payload_t head_frame,   // Oldest entry, shown ahead
  output logic     full,         // No room left
  output logic     empty         // Nothing stored
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width
  localparam int CNT_W = $clog2(DEPTH + 1);                // Occupancy width

  payload_t             mem [DEPTH];  // Storage, no reset
  logic [PTR_W-1:0]     wr_ptr;       // Next slot to write
  logic [PTR_W-1:0]     rd_ptr;       // Slot shown on head
  logic [CNT_W-1:0]     count;        // Entries held
  logic                 wr_en;        // Accepted push
  logic                 rd_en;        // Accepted pop

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // Strobes are gated upstream, guard again here
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  // Show-ahead read
  assign head_frame = mem[rd_ptr];

  always_ff @(posedge AUD_DACLRCK) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_frame;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge AUD_DACLRCK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Simultaneous push and pop leave the count alone
  always_ff @(posedge AUD_DACLRCK) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Both neighbours must honour the levels
  a_no_pop_when_empty: assert property (
    @(posedge AUD_DACLRCK) disable iff (reset)
    empty |-> !pop
  ) else $error("sample_fifo popped while empty");

  a_no_push_when_full: assert property (
    @(posedge AUD_DACLRCK) disable iff (reset)
    full |-> !push
  ) else $error("sample_fifo pushed while full");

endmodule

//--- verilog/dac_frame_sink.sv
`timescale 1ns/1ps

module dac_frame_sink (
  input  logic                            AUD_DACLRCK,  // Frame clock
  input  logic                            reset,        // Sync, active high
  input  logic                            hold,         // Codec not ready
  input  audio_pkg::stereo_frame_t        head_frame,   // FIFO head
  input  logic                            empty,        // FIFO has nothing
  output logic                            pop,          // Take the head
  output audio_pkg::sample_t              audio_out_l,  // Left DAC word
  output audio_pkg::sample_t              audio_out_r,  // Right DAC word
  output logic [audio_pkg::LED_BARS-1:0]  ledr          // Peak bar
);

  localparam int WIN_W = $clog2(audio_pkg::PEAK_WINDOW);  // Window counter width

  logic [WIN_W-1:0]              win_cnt;    // Frame slots in this window
  logic                          win_end;    // Last slot of the window
  logic [audio_pkg::SAMPLE_W-1:0] abs_left;  // |left| of the head
  logic [audio_pkg::SAMPLE_W-1:0] peak_q;    // Running peak
  logic [audio_pkg::SAMPLE_W-1:0] peak_next; // Peak including this slot

  // Thermometer of (peak >> PEAK_SHIFT) + 1 LEDs, dark for silence
  function automatic logic [audio_pkg::LED_BARS-1:0] peak_bar(
    logic [audio_pkg::SAMPLE_W-1:0] peak
  );
    int lit;
    logic [audio_pkg::LED_BARS-1:0] bar;
    if (peak == '0) begin
      lit = 0;
    end else begin
      lit = int'(peak >> audio_pkg::PEAK_SHIFT) + 1;
    end
    for (int i = 0; i < audio_pkg::LED_BARS; i++) begin
      bar[i] = (i < lit);
    end
    return bar;
  endfunction

  assign pop = !empty && !hold;  // Drain one frame per ready slot

  // Register the popped frame, hold it otherwise
  always_ff @(posedge AUD_DACLRCK) begin
    if (reset) begin
      audio_out_l <= '0;
      audio_out_r <= '0;
    end else if (pop) begin
      audio_out_l <= head_frame.left;
      audio_out_r <= head_frame.right;
    end
  end

  // Magnitude, -32768 maps to 0x8000
  assign abs_left = head_frame.left[audio_pkg::SAMPLE_W-1] ?
                    audio_pkg::SAMPLE_W'(-head_frame.left) :
                    audio_pkg::SAMPLE_W'(head_frame.left);

  always_comb begin
    peak_next = peak_q;
    if (pop && (abs_left > peak_q)) begin
      peak_next = abs_left;  // New maximum
    end
  end

  assign win_end = (win_cnt == WIN_W'(audio_pkg::PEAK_WINDOW - 1));

  // Window runs on codec-ready frame slots, so a silent producer
  // still closes windows and lets the bar fall to zero
  always_ff @(posedge AUD_DACLRCK) begin
    if (reset) begin
      win_cnt <= '0;
      peak_q  <= '0;
      ledr    <= '0;
    end else if (!hold) begin
      win_cnt <= win_cnt + 1'b1;  // Wraps at window size
      if (win_end) begin
        ledr   <= peak_bar(peak_next);  // Publish and restart
        peak_q <= '0;
      end else begin
        peak_q <= peak_next;
      end
    end
  end

  // A popped head must have been written by the producer
  a_pop_known: assert property (
    @(posedge AUD_DACLRCK) disable iff (reset)
    pop |-> !$isunknown(head_frame)
  ) else $error("dac_frame_sink popped an unwritten frame");

endmodule

//--- verilog/tone_subsystem.sv
`timescale 1ns/1ps

module tone_subsystem (
  input  logic                            AUD_DACLRCK,  // DAC LR clock, one per frame
  input  logic                            reset,        // Sync, active high
  input  logic [17:0]                     sw,           // Board switches
  output audio_pkg::sample_t              audio_out_l,  // To codec left
  output audio_pkg::sample_t              audio_out_r,  // To codec right
  output logic [audio_pkg::LED_BARS-1:0]  ledr          // Red LEDs
);

  audio_pkg::tone_cfg_t      cfg;         // Decoded settings
  logic                      hold;        // Codec not ready
  logic                      push;        // Producer strobe
  logic                      full;        // FIFO full level
  logic                      pop;         // Sink strobe
  logic                      empty;       // FIFO empty level
  audio_pkg::stereo_frame_t  push_frame;  // Producer to FIFO
  audio_pkg::stereo_frame_t  head_frame;  // FIFO to sink

  // Switch map, sw[16:11] spare
  assign cfg.half_period = sw[5:0];
  assign cfg.enable      = sw[6];
  assign cfg.antiphase   = sw[7];
  assign cfg.amp_code    = sw[10:8];
  assign hold            = sw[17];

  square_tone_gen u_gen (
    .AUD_DACLRCK (AUD_DACLRCK),
    .reset       (reset),
    .cfg         (cfg),
    .full        (full),
    .push        (push),
    .push_frame  (push_frame)
  );

  sample_fifo #(
    .payload_t (audio_pkg::stereo_frame_t),
    .DEPTH     (audio_pkg::FIFO_DEPTH)
  ) u_fifo (
    .AUD_DACLRCK (AUD_DACLRCK),
    .reset       (reset),
    .push        (push),
    .push_frame  (push_frame),
    .pop         (pop),
    .head_frame  (head_frame),
    .full        (full),
    .empty       (empty)
  );

  dac_frame_sink u_sink (
    .AUD_DACLRCK (AUD_DACLRCK),
    .reset       (reset),
    .hold        (hold),
    .head_frame  (head_frame),
    .empty       (empty),
    .pop         (pop),
    .audio_out_l (audio_out_l),
    .audio_out_r (audio_out_r),
    .ledr        (ledr)
  );

endmodule

//--- tb/tb_tone_subsystem.sv
`timescale 1ns/1ps

module tb_tone_subsystem;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int GAP          = 16;   // Tone off, FIFO drains
  localparam int SQ_PHASES    = 4;
  localparam int SQ_CYCLES    = 384;  // Six runs at the longest setting
  localparam int BP_WARM      = 192;
  localparam int BP_HOLD      = 24;   // Longer than the FIFO depth
  localparam int BP_RUN       = 256;
  localparam int PEAK_WAIT    = 2 * audio_pkg::PEAK_WINDOW + 8;
  localparam int TOTAL_CYCLES = RESET_CYCLES + 8 + SQ_PHASES * (SQ_CYCLES + GAP) +
                                BP_WARM + BP_HOLD + BP_RUN + GAP + 2 * PEAK_WAIT + GAP + 2;

  logic                           AUD_DACLRCK;
  logic                           reset;
  logic [17:0]                    sw;
  audio_pkg::sample_t             audio_out_l;
  audio_pkg::sample_t             audio_out_r;
  logic [audio_pkg::LED_BARS-1:0] ledr;

  logic [31:0]                    lcg_state;
  int                             errors;
  int                             n_pass;
  int                             n_fail;
  string                          cur_test;
  logic                           track;        // Run tracker on
  logic                           reset_check;  // Outputs must be zero
  logic                           bar_check;    // Compare ledr once
  logic [audio_pkg::LED_BARS-1:0] exp_bar;
  logic                           hold_d;       // Hold of the previous cycle
  audio_pkg::sample_t             prev_l;
  int                             run_len;      // Fresh samples in current run
  int                             last_run;
  int                             trans_cnt;    // Level changes seen, saturates
  int                             runs_seen;
  logic                           run_done;
  audio_pkg::sample_t             exp_amp;
  int                             exp_run;
  logic                           levels_ok;

  tone_subsystem dut0 (
    .AUD_DACLRCK (AUD_DACLRCK),
    .reset       (reset),
    .sw          (sw),
    .audio_out_l (audio_out_l),
    .audio_out_r (audio_out_r),
    .ledr        (ledr)
  );

  always #(CLK_PERIOD / 2) AUD_DACLRCK = ~AUD_DACLRCK;

  // Amplitude step of 4096 on top of 0x0FFF
  function automatic audio_pkg::sample_t expected_amplitude(logic [2:0] code);
    return audio_pkg::sample_t'(int'(code) * 4096 + 4095);
  endfunction

  // One lit LED per amplitude code step, plus one for the base level
  function automatic logic [audio_pkg::LED_BARS-1:0] lit_bar(logic [2:0] code);
    int lit;
    logic [audio_pkg::LED_BARS-1:0] bar;
    lit = int'(code) + 1;
    for (int i = 0; i < audio_pkg::LED_BARS; i++) begin
      bar[i] = (i < lit);
    end
    return bar;
  endfunction

  function automatic logic [17:0] switch_word(logic hold, logic [2:0] code, logic anti,
                                               logic en, logic [5:0] hp);
    return {hold, 6'b0, code, anti, en, hp};  // sw[16:11] spare
  endfunction

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  assign exp_amp   = expected_amplitude(sw[10:8]);
  assign exp_run   = int'(sw[5:0]) + 1;
  assign levels_ok = track && (trans_cnt >= 2);  // First two runs may be partial

  // Run lengths over fresh output samples only
  always @(posedge AUD_DACLRCK) begin
    hold_d <= sw[17];
    if (reset || !track) begin
      run_len   <= 0;
      trans_cnt <= 0;
      runs_seen <= 0;
      run_done  <= 1'b0;
      prev_l    <= audio_out_l;
    end else begin
      run_done <= 1'b0;
      if (!hold_d) begin  // Output was refreshed by a pop
        if (audio_out_l != prev_l) begin
          if (trans_cnt >= 2) begin
            run_done  <= 1'b1;
            last_run  <= run_len;
            runs_seen <= runs_seen + 1;
          end
          if (trans_cnt < 2) begin
            trans_cnt <= trans_cnt + 1;
          end
          run_len <= 1;  // New value opens a run
        end else begin
          run_len <= run_len + 1;
        end
        prev_l <= audio_out_l;
      end
    end
  end

  a_reset_zero: assert property (@(posedge AUD_DACLRCK)
    reset_check |-> (audio_out_l == '0 && audio_out_r == '0 && ledr == '0)
  ) else begin
    errors++;
    $display("Fail reset_state expected l=0 r=0 ledr=0 actual l=%0d r=%0d ledr=%h",
             $sampled(audio_out_l), $sampled(audio_out_r), $sampled(ledr));
  end

  a_run_length: assert property (@(posedge AUD_DACLRCK) disable iff (reset)
    (track && run_done) |-> (last_run == exp_run)
  ) else begin
    errors++;
    $display("Fail %s run length expected %0d actual %0d",
             cur_test, $sampled(exp_run), $sampled(last_run));
  end

  a_levels: assert property (@(posedge AUD_DACLRCK) disable iff (reset)
    levels_ok |-> (audio_out_l == '0 || audio_out_l == exp_amp)
  ) else begin
    errors++;
    $display("Fail %s left level expected 0 or %0d actual %0d",
             cur_test, $sampled(exp_amp), $sampled(audio_out_l));
  end

  a_channels: assert property (@(posedge AUD_DACLRCK) disable iff (reset)
    levels_ok |-> (audio_out_r == (sw[7] ? (audio_out_l ^ exp_amp) : audio_out_l))
  ) else begin
    errors++;
    $display("Fail %s right channel expected %0d actual %0d", cur_test,
             $sampled(sw[7] ? (audio_out_l ^ exp_amp) : audio_out_l), $sampled(audio_out_r));
  end

  // Hold of the previous cycle froze this cycle's outputs
  a_hold_freeze: assert property (@(posedge AUD_DACLRCK) disable iff (reset)
    hold_d |-> ($stable(audio_out_l) && $stable(audio_out_r))
  ) else begin
    errors++;
    $display("Fail %s outputs moved while the codec was not ready", cur_test);
  end

  a_peak_bar: assert property (@(posedge AUD_DACLRCK) disable iff (reset)
    bar_check |-> (ledr == exp_bar)
  ) else begin
    errors++;
    $display("Fail %s ledr expected %h actual %h", cur_test, $sampled(exp_bar), $sampled(ledr));
  end

  task automatic cycles(input int n);
    repeat (n) @(posedge AUD_DACLRCK);
  endtask

  task automatic start_tone(input string name, input logic anti, input logic [5:0] hp,
                            input logic [2:0] code);
    cur_test = name;
    sw    <= switch_word(1'b0, code, anti, 1'b1, hp);
    track <= 1'b1;
  endtask

  // Ends a tone phase and lets the FIFO drain
  task automatic stop_tone();
    if (runs_seen < 2) begin
      errors++;
      $display("%s never completed two checked square-wave runs", cur_test);
    end
    track <= 1'b0;
    sw    <= '0;
    cycles(GAP);
  endtask

  task automatic finish_test(input string name, input int err0);
    if (errors == err0) begin
      n_pass++;
      $display("%-14s ok", name);
    end else begin
      n_fail++;
      $display("%-14s failed with %0d errors", name, errors - err0);
    end
  endtask

  initial begin
    int err0;
    logic [31:0] r;
    AUD_DACLRCK = 1'b0;
    reset       = 1'b1;
    sw          = '0;
    track       = 1'b0;
    reset_check = 1'b0;
    bar_check   = 1'b0;
    exp_bar     = '0;
    lcg_state   = 32'hf512_4647;
    errors      = 0;
    n_pass      = 0;
    n_fail      = 0;
    cur_test    = "reset_state";

    cycles(RESET_CYCLES);
    reset       <= 1'b0;
    reset_check <= 1'b1;  // Tone still off
    cycles(8);
    reset_check <= 1'b0;
    finish_test("reset_state", 0);

    for (int i = 0; i < SQ_PHASES; i++) begin
      err0 = errors;
      r    = next_random();
      start_tone($sformatf("square_%0d", i), i[0], r[21:16], r[26:24]);  // Odd phases antiphase
      cycles(SQ_CYCLES);
      stop_tone();
      finish_test($sformatf("square_%0d", i), err0);
    end

    err0 = errors;
    r    = next_random();
    start_tone("backpressure", r[31], r[21:16], r[26:24]);
    cycles(BP_WARM);
    sw[17] <= 1'b1;  // FIFO fills, producer stalls
    cycles(BP_HOLD);
    sw[17] <= 1'b0;
    cycles(BP_RUN);
    stop_tone();
    finish_test("backpressure", err0);

    err0 = errors;
    r    = next_random();
    start_tone("peak_bar", 1'b0, {2'b00, r[19:16]}, r[26:24]);  // Short period, high level in every window
    exp_bar <= lit_bar(r[26:24]);
    cycles(PEAK_WAIT);
    bar_check <= 1'b1;
    cycles(1);
    bar_check <= 1'b0;
    stop_tone();
    exp_bar <= '0;  // Silent windows turn the bar off
    cycles(PEAK_WAIT);
    bar_check <= 1'b1;
    cycles(1);
    bar_check <= 1'b0;
    finish_test("peak_bar", err0);

    $display("Tests %0d, ok %0d, failed %0d, check errors %0d",
             n_pass + n_fail, n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the phase lengths
  initial begin
    #(CLK_PERIOD * (TOTAL_CYCLES + 200));
    $display("Watchdog expired before the test sequence finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- src.f
verilog/audio_pkg.sv
verilog/square_tone_gen.sv
verilog/sample_fifo.sv
verilog/dac_frame_sink.sv
verilog/tone_subsystem.sv
tb/tb_tone_subsystem.sv

//--- Bender.yml
package:
  name: tone_subsystem

sources:
  - verilog/audio_pkg.sv
  - verilog/square_tone_gen.sv
  - verilog/sample_fifo.sv
  - verilog/dac_frame_sink.sv
  - verilog/tone_subsystem.sv
  - target: test
    files:
      - tb/tb_tone_subsystem.sv
